/* hw/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

  // host to mouse command and the mouse reply to it.
  localparam logic [7:0] cmd_enable = 8'hf4;
  localparam logic [7:0] resp_ack   = 8'hfa;

  // wishbone word addresses.
  localparam logic [1:0] reg_status = 2'd0;
  localparam logic [1:0] reg_x      = 2'd1;
  localparam logic [1:0] reg_y      = 2'd2;
  localparam logic [1:0] reg_count  = 2'd3;

  localparam int bus_w = 16;

  typedef struct packed {
    logic y_ovf;
    logic x_ovf;
    logic y_sign;
    logic x_sign;
    logic sync;
    logic middle;
    logic right;
    logic left;
  } first_flags_t;

  // first byte of a movement packet.
  typedef union packed {
    logic [7:0]   raw;
    first_flags_t flags;
  } first_byte_u;

endpackage

`default_nettype wire

/* hw/ps2_cmd_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_cmd_tx #(
  parameter int hold_cycles = 200
) (
  input  logic clk,
  input  logic rst,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic ps2_clk_oe,
  output logic ps2_data_oe,
  output logic init_done
);
  import ps2_pkg::*;

  localparam int cnt_w = $clog2(hold_cycles + 1);

  localparam logic [2:0] st_hold    = 3'd0;
  localparam logic [2:0] st_request = 3'd1;
  localparam logic [2:0] st_shift   = 3'd2;
  localparam logic [2:0] st_stop    = 3'd3;
  localparam logic [2:0] st_ack     = 3'd4;

  logic [2:0]       state;
  logic [cnt_w-1:0] hold_cnt;
  logic [8:0]       tx_shift;
  logic [3:0]       bit_cnt;
  logic [2:0]       clk_sync;
  logic [1:0]       data_sync;
  logic             clk_fall;

  // two sync flops, the third stage is the edge register.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_sync  <= 3'b111;
      data_sync <= 2'b11;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= st_hold;
      hold_cnt    <= '0;
      tx_shift    <= {~^cmd_enable, cmd_enable};
      bit_cnt     <= '0;
      ps2_clk_oe  <= 1'b0;
      ps2_data_oe <= 1'b0;
      init_done   <= 1'b0;
    end else begin
      case (state)
        st_hold: begin
          if (hold_cnt == cnt_w'(hold_cycles)) begin
            // release clock, start bit goes out on data.
            ps2_clk_oe  <= 1'b0;
            ps2_data_oe <= 1'b1;
            state       <= st_request;
          end else begin
            ps2_clk_oe <= 1'b1;
            hold_cnt   <= hold_cnt + 1'b1;
          end
        end
        st_request: begin
          // wait until the released clock line reads high.
          if (clk_sync[1]) begin
            state <= st_shift;
          end
        end
        st_shift: begin
          if (clk_fall) begin
            ps2_data_oe <= ~tx_shift[0];
            tx_shift    <= {1'b1, tx_shift[8:1]};
            bit_cnt     <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd8) begin
              state <= st_stop;
            end
          end
        end
        st_stop: begin
          if (clk_fall) begin
            ps2_data_oe <= 1'b0;
            state       <= st_ack;
          end
        end
        st_ack: begin
          // device pulls data low for the acknowledge bit.
          if (clk_fall && !data_sync[1]) begin
            init_done <= 1'b1;
          end
        end
        default: begin
          state <= st_hold;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/ps2_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic       init_done,
  output logic       byte_valid,
  output logic [7:0] byte_data
);

  logic [2:0] clk_sync;
  logic [1:0] data_sync;
  logic       clk_fall;
  logic       busy;
  logic [3:0] bit_cnt;
  logic [9:0] rx_shift;
  logic       frame_end;
  logic       frame_ok;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_sync  <= 3'b111;
      data_sync <= 2'b11;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];

  // odd parity over data and parity bit, stop bit must be high.
  assign frame_ok = (^rx_shift[8:0]) & rx_shift[9];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy       <= 1'b0;
      bit_cnt    <= '0;
      frame_end  <= 1'b0;
      byte_valid <= 1'b0;
    end else begin
      frame_end  <= 1'b0;
      byte_valid <= frame_end & frame_ok;
      if (!busy) begin
        if (init_done && clk_fall && !data_sync[1]) begin
          busy    <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (clk_fall) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd9) begin
          busy      <= 1'b0;
          frame_end <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && clk_fall) begin
      rx_shift <= {data_sync[1], rx_shift[9:1]};
    end
    if (frame_end && frame_ok) begin
      byte_data <= rx_shift[7:0];
    end
  end

endmodule

`default_nettype wire

/* hw/ps2_packet_asm.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_packet_asm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 byte_valid,
  input  logic [7:0]           byte_data,
  output logic                 pkt_valid,
  output ps2_pkg::first_byte_u pkt_first,
  output logic [7:0]           pkt_dx,
  output logic [7:0]           pkt_dy
);
  import ps2_pkg::*;

  localparam logic [1:0] st_wait_ack = 2'd0;
  localparam logic [1:0] st_first    = 2'd1;
  localparam logic [1:0] st_dx       = 2'd2;
  localparam logic [1:0] st_dy       = 2'd3;

  logic [1:0]  state;
  first_byte_u in_byte;
  first_byte_u first_q;
  logic [7:0]  dx_q;
  logic        pkt_load;

  always_comb begin
    in_byte.raw = byte_data;
  end

  assign pkt_load = byte_valid && (state == st_dy);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= st_wait_ack;
      pkt_valid <= 1'b0;
    end else begin
      pkt_valid <= pkt_load;
      if (byte_valid) begin
        case (state)
          st_wait_ack: begin
            if (byte_data == resp_ack) begin
              state <= st_first;
            end
          end
          // out of sync bytes are dropped here.
          st_first: begin
            if (in_byte.flags.sync) begin
              state <= st_dx;
            end
          end
          st_dx: state <= st_dy;
          default: state <= st_first;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid && state == st_first) begin
      first_q.raw <= byte_data;
    end
    if (byte_valid && state == st_dx) begin
      dx_q <= byte_data;
    end
    if (pkt_load) begin
      pkt_first <= first_q;
      pkt_dx    <= dx_q;
      pkt_dy    <= byte_data;
    end
  end

endmodule

`default_nettype wire

/* hw/pointer_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module pointer_tracker #(
  parameter int screen_w = 410,
  parameter int screen_h = 308
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pkt_valid,
  input  ps2_pkg::first_byte_u      pkt_first,
  input  logic [7:0]                pkt_dx,
  input  logic [7:0]                pkt_dy,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [1:0]                wb_adr,
  output logic [ps2_pkg::bus_w-1:0] wb_dat_o,
  output logic                      wb_ack
);
  import ps2_pkg::*;

  localparam int xw    = $clog2(screen_w);
  localparam int yw    = $clog2(screen_h);
  localparam int sum_w = bus_w + 2;

  logic [xw-1:0]    x;
  logic [xw-1:0]    x_next;
  logic [yw-1:0]    y;
  logic [yw-1:0]    y_next;
  logic [4:0]       status;
  logic [bus_w-1:0] count;
  logic [8:0]       mv_x;
  logic [8:0]       mv_y;
  logic             wb_req;
  logic [bus_w-1:0] rd_word;

  // signed add, then clamp to 0..lim.
  function automatic logic [sum_w-1:0] clamp_move(input logic [sum_w-1:0] pos,
                                                  input logic [8:0]       mv,
                                                  input logic [sum_w-1:0] lim);
    logic signed [sum_w-1:0] sum;
    sum = $signed(pos) + $signed({{(sum_w-9){mv[8]}}, mv});
    if (sum < 0) begin
      return '0;
    end
    if (sum > $signed(lim)) begin
      return lim;
    end
    return sum;
  endfunction

  // an overflowed axis does not move.
  assign mv_x = pkt_first.flags.x_ovf ? 9'd0 : {pkt_first.flags.x_sign, pkt_dx};
  assign mv_y = pkt_first.flags.y_ovf ? 9'd0 : {pkt_first.flags.y_sign, pkt_dy};

  assign x_next = xw'(clamp_move(sum_w'(x), mv_x, sum_w'(screen_w - 1)));
  assign y_next = yw'(clamp_move(sum_w'(y), mv_y, sum_w'(screen_h - 1)));

  assign wb_req = wb_cyc & wb_stb & ~wb_ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      x      <= xw'(screen_w / 2);
      y      <= yw'(screen_h / 2);
      status <= '0;
      count  <= '0;
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
      if (pkt_valid) begin
        x      <= x_next;
        y      <= y_next;
        status <= {pkt_first.flags.y_ovf, pkt_first.flags.x_ovf,
                   pkt_first.flags.middle, pkt_first.flags.right, pkt_first.flags.left};
        count  <= count + 1'b1;
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (wb_adr)
      reg_status: rd_word = bus_w'(status);
      reg_x:      rd_word = bus_w'(x);
      reg_y:      rd_word = bus_w'(y);
      reg_count:  rd_word = count;
      default:    rd_word = '0;
    endcase
  end

  // writes are acked with no effect.
  always_ff @(posedge clk) begin
    if (wb_req) begin
      wb_dat_o <= wb_we ? '0 : rd_word;
    end
  end

endmodule

`default_nettype wire

/* hw/ps2_mouse_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_top #(
  parameter int hold_cycles = 200,
  parameter int screen_w    = 410,
  parameter int screen_h    = 308
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      ps2_clk,
  input  logic                      ps2_data,
  output logic                      ps2_clk_oe,
  output logic                      ps2_data_oe,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [1:0]                wb_adr,
  output logic [ps2_pkg::bus_w-1:0] wb_dat_o,
  output logic                      wb_ack
);
  import ps2_pkg::*;

  logic        init_done;
  logic        byte_valid;
  logic [7:0]  byte_data;
  logic        pkt_valid;
  first_byte_u pkt_first;
  logic [7:0]  pkt_dx;
  logic [7:0]  pkt_dy;

  ps2_cmd_tx #(
    .hold_cycles(hold_cycles)
  ) cmd_tx_i (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .ps2_clk_oe (ps2_clk_oe),
    .ps2_data_oe(ps2_data_oe),
    .init_done  (init_done)
  );

  ps2_rx rx_i (
    .clk       (clk),
    .rst       (rst),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .init_done (init_done),
    .byte_valid(byte_valid),
    .byte_data (byte_data)
  );

  ps2_packet_asm asm_i (
    .clk       (clk),
    .rst       (rst),
    .byte_valid(byte_valid),
    .byte_data (byte_data),
    .pkt_valid (pkt_valid),
    .pkt_first (pkt_first),
    .pkt_dx    (pkt_dx),
    .pkt_dy    (pkt_dy)
  );

  pointer_tracker #(
    .screen_w(screen_w),
    .screen_h(screen_h)
  ) tracker_i (
    .clk      (clk),
    .rst      (rst),
    .pkt_valid(pkt_valid),
    .pkt_first(pkt_first),
    .pkt_dx   (pkt_dx),
    .pkt_dy   (pkt_dy),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

endmodule

`default_nettype wire

/* tb/ps2_mouse_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_chk (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic ps2_clk_oe,
  input logic ps2_data_oe
);

  ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for two cycles");

  // ack only follows a request that was not yet acknowledged.
  ack_after_request: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
    else $error("wb_ack raised without a request");

  oe_low_in_reset: assert property (@(posedge clk) rst |-> (!ps2_clk_oe && !ps2_data_oe))
    else $error("open-collector enable high during reset");

endmodule

bind pointer_tracker ps2_mouse_chk tracker_chk_i (
  .clk        (clk),
  .rst        (rst),
  .wb_cyc     (wb_cyc),
  .wb_stb     (wb_stb),
  .wb_ack     (wb_ack),
  .ps2_clk_oe (1'b0),
  .ps2_data_oe(1'b0)
);

bind ps2_cmd_tx ps2_mouse_chk cmd_chk_i (
  .clk        (clk),
  .rst        (rst),
  .wb_cyc     (1'b0),
  .wb_stb     (1'b0),
  .wb_ack     (1'b0),
  .ps2_clk_oe (ps2_clk_oe),
  .ps2_data_oe(ps2_data_oe)
);

`default_nettype wire

/* tb/tb_ps2_mouse.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_mouse;
  import ps2_pkg::*;

  localparam int hold_len = 40;
  localparam int half_bit = 10;
  localparam int frame_gap = 30;
  localparam int settle_cycles = 300;

  typedef struct packed {
    logic [1:0]       nbytes;
    logic [2:0][7:0]  pkt;
    logic             bad_par;
    logic [bus_w-1:0] status;
    logic [bus_w-1:0] x;
    logic [bus_w-1:0] y;
    logic [bus_w-1:0] count;
  } entry_t;

  logic             clk = 1'b0;
  logic             rst;
  logic             dev_clk;
  logic             dev_data;
  logic             ps2_clk;
  logic             ps2_data;
  logic             ps2_clk_oe;
  logic             ps2_data_oe;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [1:0]       wb_adr;
  logic [bus_w-1:0] wb_dat_o;
  logic             wb_ack;
  entry_t           table_q[$];

  always #2 clk = ~clk;

  // wired-AND of the mouse drive and the host pull-downs.
  assign ps2_clk  = dev_clk & ~ps2_clk_oe;
  assign ps2_data = dev_data & ~ps2_data_oe;

  ps2_mouse_top #(
    .hold_cycles(hold_len)
  ) dut_i (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .ps2_clk_oe (ps2_clk_oe),
    .ps2_data_oe(ps2_data_oe),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o),
    .wb_ack     (wb_ack)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [bus_w-1:0] got,
                            input logic [bus_w-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic add_entry(input logic [1:0] n, input logic [7:0] b0, input logic [7:0] b1,
                           input logic [7:0] b2, input logic bad,
                           input logic [bus_w-1:0] st, input logic [bus_w-1:0] x,
                           input logic [bus_w-1:0] y, input logic [bus_w-1:0] cnt);
    entry_t e;
    e.nbytes  = n;
    e.pkt     = {b2, b1, b0};
    e.bad_par = bad;
    e.status  = st;
    e.x       = x;
    e.y       = y;
    e.count   = cnt;
    table_q.push_back(e);
  endtask

  // clock in the host command as the mouse, then give the ack bit.
  task automatic read_host_frame(output logic [7:0] data, output logic par, output logic stop);
    int               t;
    logic [bus_w-1:0] low_cnt;
    logic [9:0]       bits;
    t       = 0;
    low_cnt = '0;
    @(negedge clk);
    // the host inhibits the bus by holding the clock low.
    while (ps2_clk) begin
      t++;
      if (t > 1000) begin
        abort_run("host never pulled the clock low");
      end
      @(negedge clk);
    end
    while (!ps2_clk) begin
      low_cnt = low_cnt + 1'b1;
      if (low_cnt > 16'd1000) begin
        abort_run("host held the clock low for too long");
      end
      @(negedge clk);
    end
    check_word("clock hold cycles", low_cnt, bus_w'(hold_len));
    t = 0;
    while (!(ps2_clk && !ps2_data)) begin
      t++;
      if (t > 1000) begin
        abort_run("no command from host");
      end
      @(negedge clk);
    end
    for (int i = 0; i < 10; i++) begin
      repeat (half_bit) @(posedge clk);
      dev_clk <= 1'b0;
      repeat (half_bit - 1) @(posedge clk);
      @(negedge clk);
      bits = {ps2_data, bits[9:1]};
      @(posedge clk);
      dev_clk <= 1'b1;
    end
    repeat (5) @(posedge clk);
    dev_data <= 1'b0;
    repeat (5) @(posedge clk);
    dev_clk <= 1'b0;
    repeat (half_bit) @(posedge clk);
    dev_clk <= 1'b1;
    repeat (5) @(posedge clk);
    dev_data <= 1'b1;
    data = bits[7:0];
    par  = bits[8];
    stop = bits[9];
  endtask

  // send a mouse to host frame with the parity inverted when bad is set.
  task automatic send_frame(input logic [7:0] b, input logic bad);
    logic [10:0] frame;
    frame = {1'b1, (bad ? ^b : ~^b), b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      dev_data <= frame[0];
      frame = {1'b1, frame[10:1]};
      repeat (5) @(posedge clk);
      dev_clk <= 1'b0;
      repeat (half_bit) @(posedge clk);
      dev_clk <= 1'b1;
      repeat (5) @(posedge clk);
    end
    @(posedge clk);
    dev_data <= 1'b1;
  endtask

  task automatic bus_cycle(input logic we, input logic [1:0] adr, output logic [bus_w-1:0] data);
    int t;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= we;
    wb_adr <= adr;
    t = 0;
    @(negedge clk);
    while (!wb_ack) begin
      t++;
      if (t > 20) begin
        abort_run("no wishbone acknowledge");
      end
      @(negedge clk);
    end
    data = wb_dat_o;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      abort_run("wishbone acknowledge held for more than one cycle");
    end
  endtask

  task automatic check_regs(input logic [bus_w-1:0] st, input logic [bus_w-1:0] x,
                            input logic [bus_w-1:0] y, input logic [bus_w-1:0] cnt);
    logic [bus_w-1:0] rd;
    bus_cycle(1'b0, reg_status, rd);
    check_word("status", rd, st);
    bus_cycle(1'b0, reg_x, rd);
    check_word("x", rd, x);
    bus_cycle(1'b0, reg_y, rd);
    check_word("y", rd, y);
    bus_cycle(1'b0, reg_count, rd);
    check_word("count", rd, cnt);
  endtask

  initial begin
    entry_t           e;
    logic [1:0]       j;
    logic [7:0]       cmd;
    logic             par;
    logic             stop;
    logic [bus_w-1:0] rd;
    rst      = 1'b1;
    dev_clk  = 1'b1;
    dev_data = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 2'd0;

    // bytes, bad parity, then status, x, y, count after the entry.
    add_entry(2'd3, 8'h08, 8'h10, 8'h10, 1'b0, 16'h00, 16'd205, 16'd154, 16'd0);
    add_entry(2'd1, resp_ack, 8'h00, 8'h00, 1'b0, 16'h00, 16'd205, 16'd154, 16'd0);
    add_entry(2'd3, 8'h2b, 8'h14, 8'hf6, 1'b0, 16'h03, 16'd225, 16'd144, 16'd1);
    add_entry(2'd3, 8'h2c, 8'hff, 8'h01, 1'b0, 16'h04, 16'd409, 16'd0, 16'd2);
    add_entry(2'd3, 8'h18, 8'h01, 8'hff, 1'b0, 16'h00, 16'd154, 16'd255, 16'd3);
    add_entry(2'd3, 8'h18, 8'h01, 8'hff, 1'b0, 16'h00, 16'd0, 16'd307, 16'd4);
    add_entry(2'd3, 8'h69, 8'h50, 8'hec, 1'b0, 16'h09, 16'd0, 16'd287, 16'd5);
    add_entry(2'd3, 8'h88, 8'h0a, 8'h33, 1'b0, 16'h10, 16'd10, 16'd287, 16'd6);
    add_entry(2'd1, 8'h09, 8'h00, 8'h00, 1'b1, 16'h10, 16'd10, 16'd287, 16'd6);
    add_entry(2'd1, 8'h00, 8'h00, 8'h00, 1'b0, 16'h10, 16'd10, 16'd287, 16'd6);
    add_entry(2'd3, 8'h0a, 8'h05, 8'h03, 1'b0, 16'h02, 16'd15, 16'd290, 16'd7);

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    read_host_frame(cmd, par, stop);
    check_byte("host command", cmd, cmd_enable);
    if (^{par, cmd} != 1'b1) begin
      abort_run("host command parity is not odd");
    end
    if (!stop) begin
      abort_run("host did not release data for the stop bit");
    end
    repeat (50) @(posedge clk);
    check_regs(16'h00, 16'd205, 16'd154, 16'd0);

    for (int i = 0; i < table_q.size(); i++) begin
      e = table_q[i];
      for (j = 2'd0; j < e.nbytes; j = j + 2'd1) begin
        send_frame(e.pkt[j], e.bad_par);
        repeat (frame_gap) @(posedge clk);
      end
      repeat (settle_cycles) @(posedge clk);
      check_regs(e.status, e.x, e.y, e.count);
    end

    // writes are acknowledged and leave every register as it was.
    for (int a = 0; a < 4; a++) begin
      bus_cycle(1'b1, a[1:0], rd);
    end
    check_regs(e.status, e.x, e.y, e.count);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/ps2_pkg.sv
hw/ps2_cmd_tx.sv
hw/ps2_rx.sv
hw/ps2_packet_asm.sv
hw/pointer_tracker.sv
hw/ps2_mouse_top.sv
tb/ps2_mouse_chk.sv
tb/tb_ps2_mouse.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ps2_mouse -f all.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1
